//--- design/tap_race_defines.svh
/*
 * tap race shared constants
 * step pattern, counter widths and board key/switch mapping
 */

`ifndef TAP_RACE_DEFINES_SVH
`define TAP_RACE_DEFINES_SVH

// pattern length a player has to climb
`define TR_STEPS    33

// bit i set = step i wants the right button, clear = left button
// bit 0 upward: R L L R L L L R L R R L R L L R R L R R R L R L R L L L R L R R L
`define TR_PATTERN  33'h0_d15d_9689

`define TR_STEP_W   6               // holds 0..33
`define TR_MISS_W   8               // saturates at 255

// buttons on the board, active low
`define TR_KEYS         4
`define TR_KEY_P1_RIGHT 0
`define TR_KEY_P1_LEFT  1
`define TR_KEY_P2_RIGHT 2
`define TR_KEY_P2_LEFT  3

// slide switches
`define TR_SW_START 0
`define TR_SW_RESET 1

`endif

//--- design/tap_race_pkg.sv
/*
 * tap race types
 * game state, step and miss counters, display nibble and segment vector
 */

`include "tap_race_defines.svh"

package tap_race_pkg;

    typedef enum logic [1:0] {
        IDLE = 2'd0,                        // waiting for start switch
        PLAY = 2'd1,                        // players climbing
        DONE = 2'd2                         // somebody reached the top
    } game_state_t;

    typedef logic [`TR_STEP_W-1:0] step_t;  // position in pattern
    typedef logic [`TR_MISS_W-1:0] miss_t;  // wrong presses
    typedef logic [3:0]            hex_digit_t;
    typedef logic [6:0]            seg7_t;  // {g,f,e,d,c,b,a}, active low

endpackage

//--- design/key_press_edge.sv
/*
 * key press edge detector
 * samples active-low buttons and gives one pulse per press
 */

`timescale 1ns/1ns

module key_press_edge #(
    parameter int n_keys = 4
) (
    input  logic              clk,
    input  logic              resetn,          // sync, active high
    input  logic [n_keys-1:0] key,             // raw buttons, low = pressed
    output logic [n_keys-1:0] press            // one cycle per press
);

    logic [n_keys-1:0] key_now;                // current sample, high = down
    logic [n_keys-1:0] key_prev;               // sample one cycle older

    always_ff @(posedge clk) begin
        if (resetn) begin
            key_now  <= '0;                    // all buttons up
            key_prev <= '0;
        end else begin
            key_now  <= ~key;                  // flip to active high
            key_prev <= key_now;
        end
    end

    // down now, up before -> new press
    // registered so the pulse sits in the cycle after the second sample
    always_ff @(posedge clk) begin
        if (resetn) begin
            press <= '0;
        end else begin
            press <= key_now & ~key_prev;      // held key gives nothing more
        end
    end

endmodule

//--- design/race_control.sv
/*
 * race control
 * idle/play/done game FSM driven by the start switch,
 * latches which player (or both) finished first
 */

`timescale 1ns/1ns

module race_control (
    input  logic                      clk,
    input  logic                      resetn,     // sync, active high
    input  logic                      start,      // start switch level
    input  logic [1:0]                finished,   // {p2, p1}
    output tap_race_pkg::game_state_t state,
    output logic [1:0]                winner      // {p2, p1}
);

    tap_race_pkg::game_state_t next_state;

    // next state
    always_comb begin
        next_state = state;                            // hold by default
        case (state)
            tap_race_pkg::IDLE: begin
                if (start) next_state = tap_race_pkg::PLAY;
            end
            tap_race_pkg::PLAY: begin
                if (!start) begin
                    next_state = tap_race_pkg::IDLE;   // switch dropped mid game
                end else if (|finished) begin
                    next_state = tap_race_pkg::DONE;
                end
            end
            tap_race_pkg::DONE: begin
                if (!start) next_state = tap_race_pkg::IDLE;
            end
            default: next_state = tap_race_pkg::IDLE;  // unused encoding
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= tap_race_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // winner latch
    // captured on the play->done edge, tie keeps both bits
    always_ff @(posedge clk) begin
        if (resetn) begin
            winner <= 2'b00;
        end else if (state == tap_race_pkg::PLAY && next_state == tap_race_pkg::DONE) begin
            winner <= finished;
        end else if (next_state != tap_race_pkg::DONE) begin
            winner <= 2'b00;                           // clears as we leave done
        end
    end

    // flags only ever show while the game sits in done
    a_winner_only_in_done: assert property (
        @(posedge clk) disable iff (resetn)
        (winner != 2'b00) |-> (state == tap_race_pkg::DONE)
    );

    // a game has to be played before it can end
    a_no_idle_to_done: assert property (
        @(posedge clk) disable iff (resetn)
        (state == tap_race_pkg::IDLE) |=> (state != tap_race_pkg::DONE)
    );

endmodule

//--- design/player_track.sv
/*
 * player track
 * follows one player up the left/right pattern, counts wrong presses
 * (saturating) and flags reaching the top
 */

`timescale 1ns/1ns

`include "tap_race_defines.svh"

module player_track (
    input  logic                      clk,
    input  logic                      resetn,     // sync, active high
    input  tap_race_pkg::game_state_t state,
    input  logic                      left,       // press pulse
    input  logic                      right,      // press pulse
    output tap_race_pkg::step_t       step,       // boxes climbed so far
    output tap_race_pkg::miss_t       miss,       // wrong presses
    output logic                      finished    // top reached
);

    localparam logic [`TR_STEPS-1:0] pattern   = `TR_PATTERN;
    localparam tap_race_pkg::step_t  top_step  = tap_race_pkg::step_t'(`TR_STEPS);
    localparam tap_race_pkg::step_t  last_step = tap_race_pkg::step_t'(`TR_STEPS - 1);
    localparam tap_race_pkg::miss_t  miss_max  = '1;

    logic want_right;                       // side the current box asks for
    logic any_press;
    logic good_press;                       // single press on the right side
    logic active;                           // presses count this cycle

    // guard the index, step only reaches top_step once finished
    assign want_right = (step < top_step) ? pattern[step] : 1'b0;

    assign any_press  = left | right;
    assign good_press = (left ^ right) & (right == want_right);
    assign active     = (state == tap_race_pkg::PLAY) & ~finished;

    // step and finish flag
    always_ff @(posedge clk) begin
        if (resetn || state == tap_race_pkg::IDLE) begin
            step     <= '0;
            finished <= 1'b0;
        end else if (active && good_press) begin
            step <= step + tap_race_pkg::step_t'(1);
            if (step == last_step) finished <= 1'b1;   // same edge step hits top
        end
    end

    // miss counter
    // both buttons at once also counts as a miss
    always_ff @(posedge clk) begin
        if (resetn || state == tap_race_pkg::IDLE) begin
            miss <= '0;
        end else if (active && any_press && !good_press) begin
            if (miss != miss_max) miss <= miss + tap_race_pkg::miss_t'(1); // stick at ff
        end
    end

    a_step_in_range: assert property (
        @(posedge clk) disable iff (resetn)
        step <= top_step
    );

    // once at ff it stays there until the game goes back to idle
    a_miss_no_wrap: assert property (
        @(posedge clk) disable iff (resetn)
        (miss == miss_max && state != tap_race_pkg::IDLE) |=> (miss == miss_max)
    );

    a_finish_at_top: assert property (
        @(posedge clk) disable iff (resetn)
        finished |-> (step == top_step)
    );

endmodule

//--- design/seg7_decoder.sv
/*
 * seven segment decoder
 * hex nibble to active-low segments, g in the top bit
 */

`timescale 1ns/1ns

module seg7_decoder (
    input  tap_race_pkg::hex_digit_t digit,
    output tap_race_pkg::seg7_t      segments   // low = lit
);

    always_comb begin
        case (digit)
            4'h0: segments = 7'b100_0000;
            4'h1: segments = 7'b111_1001;
            4'h2: segments = 7'b010_0100;
            4'h3: segments = 7'b011_0000;
            4'h4: segments = 7'b001_1001;
            4'h5: segments = 7'b001_0010;
            4'h6: segments = 7'b000_0010;
            4'h7: segments = 7'b111_1000;
            4'h8: segments = 7'b000_0000;
            4'h9: segments = 7'b001_0000;
            4'ha: segments = 7'b000_1000;
            4'hb: segments = 7'b000_0011;   // lower case b
            4'hc: segments = 7'b100_0110;
            4'hd: segments = 7'b010_0001;   // lower case d
            4'he: segments = 7'b000_0110;
            4'hf: segments = 7'b000_1110;
            default: segments = 7'b111_1111; // blank
        endcase
    end

endmodule

//--- design/tap_race_top.sv
/*
 * tap race top level
 * board switch/key mapping, game control, both player tracks
 * and the miss count displays on hex4..hex7
 */

`timescale 1ns/1ns

`include "tap_race_defines.svh"

module tap_race_top (
    input  logic                clk,
    input  logic [9:0]          sw,                 // sw0 start, sw1 game reset
    input  logic [`TR_KEYS-1:0] key,                // active low buttons
    output tap_race_pkg::seg7_t hex4,               // p1 miss low nibble
    output tap_race_pkg::seg7_t hex5,               // p1 miss high nibble
    output tap_race_pkg::seg7_t hex6,               // p2 miss low nibble
    output tap_race_pkg::seg7_t hex7,               // p2 miss high nibble
    output logic [2:0]          ledr                // {p2 won, p1 won, playing}
);

    logic                      resetn;
    logic                      start;
    logic [`TR_KEYS-1:0]       press;               // one pulse per button press
    tap_race_pkg::game_state_t state;
    logic [1:0]                finished;            // {p2, p1}
    logic [1:0]                winner;
    tap_race_pkg::miss_t       miss_p1;
    tap_race_pkg::miss_t       miss_p2;

    assign resetn = sw[`TR_SW_RESET];               // high = reset the game
    assign start  = sw[`TR_SW_START];

    key_press_edge #(
        .n_keys (`TR_KEYS)
    ) u_keys (
        .clk    (clk),
        .resetn (resetn),
        .key    (key),
        .press  (press)
    );

    race_control u_ctrl (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .finished (finished),
        .state    (state),
        .winner   (winner)
    );

    player_track u_p1 (
        .clk      (clk),
        .resetn   (resetn),
        .state    (state),
        .left     (press[`TR_KEY_P1_LEFT]),
        .right    (press[`TR_KEY_P1_RIGHT]),
        .step     (),                               // debug only
        .miss     (miss_p1),
        .finished (finished[0])
    );

    player_track u_p2 (
        .clk      (clk),
        .resetn   (resetn),
        .state    (state),
        .left     (press[`TR_KEY_P2_LEFT]),
        .right    (press[`TR_KEY_P2_RIGHT]),
        .step     (),
        .miss     (miss_p2),
        .finished (finished[1])
    );

    assign ledr[0]   = (state == tap_race_pkg::PLAY);
    assign ledr[2:1] = winner;

    // miss counts, two digits per player
    seg7_decoder u_h4 (.digit (miss_p1[3:0]), .segments (hex4));
    seg7_decoder u_h5 (.digit (miss_p1[7:4]), .segments (hex5));
    seg7_decoder u_h6 (.digit (miss_p2[3:0]), .segments (hex6));
    seg7_decoder u_h7 (.digit (miss_p2[7:4]), .segments (hex7));

endmodule

//--- bench/tap_race_tb.sv
/*
 * tap race testbench
 * random and scripted presses for both players, checks the miss
 * displays and the leds against a pattern model
 */

`timescale 1ns/1ns

`include "tap_race_defines.svh"

module tap_race_tb;

    localparam int slot_cycles   = 4;               // 2 held low, 2 released
    localparam int n_idle_slots  = 20;
    localparam int n_rand_slots  = 24;              // fewer than the steps, nobody finishes
    localparam int n_extra_slots = 8;
    localparam int n_sat_slots   = 270;             // well past 255 misses
    localparam int n_all_slots   = n_idle_slots + n_rand_slots + n_extra_slots
                                   + 2 * `TR_STEPS + n_sat_slots;
    localparam int stim_cycles   = 3 + slot_cycles * n_all_slots + 40;
    localparam int cycle_limit   = 4 * stim_cycles;
    localparam int miss_top      = (1 << `TR_MISS_W) - 1;

    // press codes, bit 0 left, bit 1 right
    localparam logic [1:0] no_key    = 2'd0;
    localparam logic [1:0] left_key  = 2'd1;
    localparam logic [1:0] right_key = 2'd2;
    localparam logic [1:0] both_keys = 2'd3;

    logic                clk;
    logic [9:0]          sw;
    logic [`TR_KEYS-1:0] key;
    tap_race_pkg::seg7_t hex4;
    tap_race_pkg::seg7_t hex5;
    tap_race_pkg::seg7_t hex6;
    tap_race_pkg::seg7_t hex7;
    logic [2:0]          ledr;

    logic [31:0] lfsr_state;
    logic [1:0]  q_p1 [$];                          // presses of the current game
    logic [1:0]  q_p2 [$];
    int          errors      = 0;
    int          checks      = 0;
    int          tests       = 0;
    int          tests_bad   = 0;
    int          test_errors = 0;                   // error count when the test began
    int          cycle_count = 0;

    // climb pattern, char i is the side step i asks for
    string pattern_str = "RLLRLLLRLRRLRLLRRLRRRLRLRLLLRLRRL";

    tap_race_top UUT (
        .clk  (clk),
        .sw   (sw),
        .key  (key),
        .hex4 (hex4),
        .hex5 (hex5),
        .hex6 (hex6),
        .hex7 (hex7),
        .ledr (ledr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // taps 32 22 2 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_code(output logic [1:0] code);
        lfsr_state = lfsr_next(lfsr_state);
        code[0]    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        code[1]    = lfsr_state[0];
    endtask

    function automatic logic [1:0] side_code(input int step);
        return (pattern_str[step] == "R") ? right_key : left_key;
    endfunction

    // segments lit per digit (gfedcba, high = on), then flipped
    function automatic tap_race_pkg::seg7_t seg_of(input tap_race_pkg::hex_digit_t d);
        logic [6:0] lit;
        case (d)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // replay the recorded presses of one game
    function automatic void model_game(output int m1, output int m2, output int s1,
                                       output logic [1:0] win);
        int         steps [2];
        int         misses [2];
        logic [1:0] fin;
        logic [1:0] code;
        logic       good;
        steps  = '{0, 0};
        misses = '{0, 0};
        fin    = 2'b00;
        for (int i = 0; i < q_p1.size(); i++) begin
            if (fin != 2'b00) break;                // game over, later presses dropped
            for (int p = 0; p < 2; p++) begin
                code = (p == 0) ? q_p1[i] : q_p2[i];
                if (code == no_key) continue;
                good = (code == side_code(steps[p]));   // both keys never match
                if (good) begin
                    steps[p]++;
                    if (steps[p] == `TR_STEPS) fin[p] = 1'b1;
                end else if (misses[p] < miss_top) begin
                    misses[p]++;
                end
            end
        end
        m1  = misses[0];
        m2  = misses[1];
        s1  = steps[0];
        win = fin;                                  // tie keeps both
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // one press slot for both players, recorded for the model
    task automatic press_slot(input logic [1:0] c1, input logic [1:0] c2);
        logic [`TR_KEYS-1:0] down;
        down = '0;
        down[`TR_KEY_P1_LEFT]  = c1[0];
        down[`TR_KEY_P1_RIGHT] = c1[1];
        down[`TR_KEY_P2_LEFT]  = c2[0];
        down[`TR_KEY_P2_RIGHT] = c2[1];
        q_p1.push_back(c1);
        q_p2.push_back(c2);
        key = ~down;                                // active low
        repeat (2) next_cycle();
        key = '1;
        repeat (2) next_cycle();
    endtask

    task automatic check_seg(input string name, input tap_race_pkg::seg7_t got,
                             input tap_race_pkg::hex_digit_t digit);
        tap_race_pkg::seg7_t want;
        want = seg_of(digit);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_ledr(input logic [2:0] want);
        checks++;
        if (ledr !== want) begin
            errors++;
            $display("[FAIL] t=%0t ledr got %b expected %b", $time, ledr, want);
        end
    endtask

    task automatic check_displays(input int m1, input int m2);
        tap_race_pkg::miss_t v1;
        tap_race_pkg::miss_t v2;
        v1 = tap_race_pkg::miss_t'(m1);
        v2 = tap_race_pkg::miss_t'(m2);
        check_seg("hex4", hex4, v1[3:0]);
        check_seg("hex5", hex5, v1[7:4]);
        check_seg("hex6", hex6, v2[3:0]);
        check_seg("hex7", hex7, v2[7:4]);
    endtask

    task automatic check_model(input logic playing);
        int         m1;
        int         m2;
        int         s1;
        logic [1:0] win;
        model_game(m1, m2, s1, win);
        check_displays(m1, m2);
        check_ledr({win, playing});
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic set_start(input logic level);
        sw[`TR_SW_START] = level;
        repeat (3) next_cycle();                    // state moves, counters clear
    endtask

    initial begin
        int         m1;
        int         m2;
        int         s1;
        logic [1:0] win;
        logic [1:0] c1;
        logic [1:0] c2;
        sw                = '0;
        sw[`TR_SW_RESET]  = 1'b1;
        key               = '1;                     // all buttons up
        lfsr_state        = 32'hd3bd_875a;
        repeat (3) @(posedge clk);
        #5;
        sw[`TR_SW_RESET] = 1'b0;
        next_cycle();

        check_displays(0, 0);
        check_ledr(3'b000);
        finish_test("after reset");

        for (int i = 0; i < n_idle_slots; i++) begin
            rand_code(c1);
            rand_code(c2);
            press_slot(c1, c2);
        end
        check_displays(0, 0);                       // idle drops every press
        check_ledr(3'b000);
        finish_test("presses while idle");

        q_p1.delete();
        q_p2.delete();
        set_start(1'b1);
        check_ledr(3'b001);
        for (int i = 0; i < n_rand_slots; i++) begin
            rand_code(c1);
            rand_code(c2);
            press_slot(c1, c2);
        end
        check_model(1'b1);
        finish_test("random play");

        model_game(m1, m2, s1, win);
        for (int i = s1; i < `TR_STEPS; i++) begin
            press_slot(side_code(i), no_key);       // rest of the climb, no mistakes
        end
        check_ledr(3'b010);
        for (int i = 0; i < n_extra_slots; i++) begin
            rand_code(c1);
            rand_code(c2);
            press_slot(c1, c2);
        end
        check_model(1'b0);
        finish_test("player one wins");

        set_start(1'b0);
        check_displays(0, 0);
        check_ledr(3'b000);
        q_p1.delete();
        q_p2.delete();
        set_start(1'b1);
        for (int i = 0; i < `TR_STEPS; i++) begin
            press_slot(side_code(i), side_code(i)); // both finish together
        end
        check_model(1'b0);
        check_ledr(3'b110);
        finish_test("tie");

        set_start(1'b0);
        q_p1.delete();
        q_p2.delete();
        set_start(1'b1);
        for (int i = 0; i < n_sat_slots; i++) begin
            press_slot(no_key, both_keys);
        end
        check_model(1'b1);
        check_displays(0, miss_top);                // sticks at ff
        finish_test("miss saturation");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+design
design/tap_race_pkg.sv
design/key_press_edge.sv
design/race_control.sv
design/player_track.sv
design/seg7_decoder.sv
design/tap_race_top.sv
bench/tap_race_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the tap race testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -f flist.f --top-module tap_race_tb \
    -o tap_race_sim > build.log 2>&1 \
    && ./obj_dir/tap_race_sim > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; cat build.log; exit 1; }

cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
